//--- design/mem_pkg.sv
package mem_pkg;

    // byte address and word sizes
    parameter int ADDR_WIDTH = 32;
    parameter int WORD_WIDTH = 32;

    // two words per block, eight bytes
    parameter int WORDS_PER_BLOCK = 2;
    parameter int BLOCK_BYTES = 8;
    parameter int BLOCK_OFS_BITS = $clog2(BLOCK_BYTES);

    // 0 is reserved as no tag / refused
    parameter int MEM_TAG_WIDTH = 4;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // whole block or word view
    typedef union packed {
        logic [WORDS_PER_BLOCK*WORD_WIDTH-1:0] block_level;
        logic [WORDS_PER_BLOCK-1:0][WORD_WIDTH-1:0] word_level;
    } mem_block_t;

    typedef logic [MEM_TAG_WIDTH-1:0] mem_tag_t;

endpackage

//--- design/fetch_pkg.sv
package fetch_pkg;

    // four packets per cycle, fixed by the two-block lookup
    parameter int FETCH_WIDTH = 4;
    parameter int FETCH_CNT_BITS = $clog2(FETCH_WIDTH + 1);

    // instruction buffer size, sets the open-entry count width
    parameter int IBUFF_DEPTH = 16;
    parameter int IBUFF_CNT_BITS = $clog2(IBUFF_DEPTH + 1);

    // one instruction toward the instruction buffer
    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] npc;
        logic        pred_taken;
    } inst_packet_t;

    // clear = prediction was right, nothing changes
    // squash = flush outputs and outstanding misses
    typedef enum logic [1:0] {
        NONE,
        CLEAR,
        SQUASH
    } br_task_t;

endpackage

//--- design/icache_port_if.sv
`timescale 1ns/1ps

interface icache_port_if;
    import mem_pkg::*;

    // two consecutive block addresses from fetch
    addr_t [1:0] lookup_addr;

    // per-block lookup results
    mem_block_t [1:0] read_data;
    logic [1:0]       hit;
    logic [1:0]       pending;

    // line reservation when a request is accepted
    logic  alloc_en;
    addr_t alloc_addr;

    // returning block from memory
    logic       fill_en;
    addr_t      fill_addr;
    mem_block_t fill_data;

    modport fetch_side (
        output lookup_addr,
        input  read_data, hit
    );

    modport cache_side (
        input  lookup_addr, alloc_en, alloc_addr, fill_en, fill_addr, fill_data,
        output read_data, hit, pending
    );

    modport tracker_side (
        input  lookup_addr, hit, pending,
        output alloc_en, alloc_addr, fill_en, fill_addr, fill_data
    );

endinterface

//--- design/icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int ICACHE_LINES = 32
) (
    input logic                 clock,
    input logic                 rst,
    input fetch_pkg::br_task_t  br_task,
    icache_port_if.cache_side   cport
);
    import mem_pkg::*;
    import fetch_pkg::*;

    localparam int IDX_BITS = $clog2(ICACHE_LINES);
    localparam int TAG_BITS = ADDR_WIDTH - IDX_BITS - BLOCK_OFS_BITS;

    // line storage, indexed by block address bits
    mem_block_t          data_mem [ICACHE_LINES];
    logic [TAG_BITS-1:0] tag_mem  [ICACHE_LINES];
    logic [ICACHE_LINES-1:0] line_valid;
    // allocated but fill not back yet
    logic [ICACHE_LINES-1:0] line_pending;

    logic [IDX_BITS-1:0] rd_idx [2];
    logic [IDX_BITS-1:0] fill_idx;
    logic [IDX_BITS-1:0] alloc_idx;

    function automatic logic [IDX_BITS-1:0] line_idx(input addr_t a);
        return a[BLOCK_OFS_BITS +: IDX_BITS];
    endfunction

    function automatic logic [TAG_BITS-1:0] line_tag(input addr_t a);
        return a[ADDR_WIDTH-1 -: TAG_BITS];
    endfunction

    assign fill_idx  = line_idx(cport.fill_addr);
    assign alloc_idx = line_idx(cport.alloc_addr);

    // two-block read, combinational
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rd_idx[i] = line_idx(cport.lookup_addr[i]);
            cport.read_data[i] = data_mem[rd_idx[i]];
            // tag match qualifies both hit and pending
            cport.hit[i] = line_valid[rd_idx[i]]
                && (tag_mem[rd_idx[i]] == line_tag(cport.lookup_addr[i]));
            cport.pending[i] = line_pending[rd_idx[i]]
                && (tag_mem[rd_idx[i]] == line_tag(cport.lookup_addr[i]));
        end
    end

    // data and tag arrays
    always_ff @(posedge clock) begin
        if (cport.fill_en) begin
            data_mem[fill_idx] <= cport.fill_data;
            tag_mem[fill_idx]  <= line_tag(cport.fill_addr);
        end
        // a new allocation retags the line, later than the fill
        if (cport.alloc_en) begin
            tag_mem[alloc_idx] <= line_tag(cport.alloc_addr);
        end
    end

    // line state
    always_ff @(posedge clock) begin
        if (rst) begin
            line_valid   <= '0;
            line_pending <= '0;
        end else begin
            if (cport.fill_en) begin
                line_valid[fill_idx]   <= 1'b1;
                line_pending[fill_idx] <= 1'b0;
            end
            // evict old contents, wait for the new block
            if (cport.alloc_en) begin
                line_valid[alloc_idx]   <= 1'b0;
                line_pending[alloc_idx] <= 1'b1;
            end
            // dropped tracker entries never fill, so forget them
            // valid lines survive the squash
            if (br_task == SQUASH) begin
                line_pending <= '0;
            end
        end
    end

endmodule

//--- design/miss_tracker.sv
`timescale 1ns/1ps

module miss_tracker #(
    parameter int NUM_MEM_TAGS = 15
) (
    input logic                 clock,
    input logic                 rst,
    input logic                 mem_grant,
    input fetch_pkg::br_task_t  br_task,
    input mem_pkg::mem_tag_t    mem_transaction_tag,
    input mem_pkg::mem_tag_t    mem_data_tag,
    input mem_pkg::mem_block_t  mem_data,
    output logic                mem_en,
    output mem_pkg::addr_t      mem_addr,
    icache_port_if.tracker_side tport
);
    import mem_pkg::*;
    import fetch_pkg::*;

    // one entry per memory tag, tag 0 unused
    logic [NUM_MEM_TAGS:1] entry_valid;
    addr_t                 entry_addr [NUM_MEM_TAGS:1];

    logic [NUM_MEM_TAGS:1] done_sel;
    logic [1:0]            in_table;
    logic                  squash;
    logic                  table_full;
    logic                  accept;

    assign squash     = (br_task == SQUASH);
    assign table_full = &entry_valid;

    // completion lookup, ignored for dropped or unknown tags
    always_comb begin
        done_sel        = '0;
        tport.fill_en   = 1'b0;
        tport.fill_addr = '0;
        for (int j = 1; j <= NUM_MEM_TAGS; j++) begin
            if (entry_valid[j] && (mem_data_tag == mem_tag_t'(j)) && !squash) begin
                done_sel[j]     = 1'b1;
                tport.fill_en   = 1'b1;
                tport.fill_addr = entry_addr[j];
            end
        end
    end

    assign tport.fill_data = mem_data;

    // is a lookup block already outstanding
    always_comb begin
        in_table = '0;
        for (int i = 0; i < 2; i++) begin
            for (int j = 1; j <= NUM_MEM_TAGS; j++) begin
                if (entry_valid[j] && (entry_addr[j][ADDR_WIDTH-1:BLOCK_OFS_BITS]
                        == tport.lookup_addr[i][ADDR_WIDTH-1:BLOCK_OFS_BITS])) begin
                    in_table[i] = 1'b1;
                end
            end
        end
    end

    // first block that still needs a load
    always_comb begin
        mem_en   = 1'b0;
        mem_addr = '0;
        if (mem_grant && !table_full && !squash) begin
            for (int i = 1; i >= 0; i--) begin
                if (!tport.hit[i] && !tport.pending[i] && !in_table[i]) begin
                    mem_en   = 1'b1;
                    mem_addr = {tport.lookup_addr[i][ADDR_WIDTH-1:BLOCK_OFS_BITS],
                                {BLOCK_OFS_BITS{1'b0}}};
                end
            end
        end
    end

    // tag 0 means refused, retry next cycle
    assign accept           = mem_en && (mem_transaction_tag != '0);
    assign tport.alloc_en   = accept;
    assign tport.alloc_addr = mem_addr;

    always_ff @(posedge clock) begin
        if (rst || squash) begin
            entry_valid <= '0;
        end else begin
            for (int j = 1; j <= NUM_MEM_TAGS; j++) begin
                // free first, a reissued tag overrides
                if (done_sel[j]) begin
                    entry_valid[j] <= 1'b0;
                end
                if (accept && (mem_transaction_tag == mem_tag_t'(j))) begin
                    entry_valid[j] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int j = 1; j <= NUM_MEM_TAGS; j++) begin
            if (accept && (mem_transaction_tag == mem_tag_t'(j))) begin
                entry_addr[j] <= mem_addr;
            end
        end
    end

endmodule

//--- design/fetch.sv
`timescale 1ns/1ps

module fetch (
    input logic                                   clock,
    input logic                                   rst,
    input mem_pkg::addr_t                         target,
    input fetch_pkg::br_task_t                    br_task,
    input logic [fetch_pkg::IBUFF_CNT_BITS-1:0]   ibuff_open,
    icache_port_if.fetch_side                     fport,
    output fetch_pkg::inst_packet_t [fetch_pkg::FETCH_WIDTH-1:0] out_insts,
    output logic [fetch_pkg::FETCH_CNT_BITS-1:0]  out_num_insts
);
    import mem_pkg::*;
    import fetch_pkg::*;

    addr_t block0_addr;
    addr_t block1_addr;

    logic [FETCH_CNT_BITS-1:0] avail;
    logic [FETCH_CNT_BITS-1:0] next_num_insts;
    inst_packet_t [FETCH_WIDTH-1:0] next_out_insts;

    // target rounded down, then the following block
    assign block0_addr = {target[ADDR_WIDTH-1:BLOCK_OFS_BITS], {BLOCK_OFS_BITS{1'b0}}};
    assign block1_addr = block0_addr + BLOCK_BYTES;

    assign fport.lookup_addr[0] = block0_addr;
    assign fport.lookup_addr[1] = block1_addr;

    // usable words up to the first missing block
    always_comb begin
        avail = '0;
        if (fport.hit[0]) begin
            // odd target word skips the first slot
            avail = target[2] ? FETCH_CNT_BITS'(1) : FETCH_CNT_BITS'(2);
            if (fport.hit[1]) begin
                avail = avail + FETCH_CNT_BITS'(2);
            end
        end
    end

    // credit cap from the instruction buffer
    always_comb begin
        if (IBUFF_CNT_BITS'(avail) > ibuff_open) begin
            next_num_insts = FETCH_CNT_BITS'(ibuff_open);
        end else begin
            next_num_insts = avail;
        end
    end

    // packets in program order from the target word
    always_comb begin
        next_out_insts = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin : build_pkt
            logic [2:0] pos;
            addr_t      pc;
            // word position counted from block 0 word 0
            pos = {2'b00, target[2]} + 3'(i);
            pc  = target + addr_t'(4 * i);
            if (i < int'(next_num_insts)) begin
                next_out_insts[i].valid      = 1'b1;
                next_out_insts[i].inst       = fport.read_data[pos[1]].word_level[pos[0]];
                next_out_insts[i].pc         = pc;
                next_out_insts[i].npc        = pc + 32'd4;
                // no branch prediction yet
                next_out_insts[i].pred_taken = 1'b0;
            end
        end
    end

    // output register, one cycle behind the lookup
    always_ff @(posedge clock) begin
        if (rst || (br_task == SQUASH)) begin
            out_insts     <= '0;
            out_num_insts <= '0;
        end else begin
            out_insts     <= next_out_insts;
            out_num_insts <= next_num_insts;
        end
    end

endmodule

//--- design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int NUM_MEM_TAGS = 15,
    parameter int ICACHE_LINES = 32
) (
    input logic                                   clock,
    input logic                                   rst,
    input mem_pkg::addr_t                         target,
    input fetch_pkg::br_task_t                    br_task,
    input logic                                   mem_grant,
    input logic [fetch_pkg::IBUFF_CNT_BITS-1:0]   ibuff_open,
    input mem_pkg::mem_tag_t                      mem_transaction_tag,
    input mem_pkg::mem_tag_t                      mem_data_tag,
    input mem_pkg::mem_block_t                    mem_data,
    output logic                                  mem_en,
    output mem_pkg::addr_t                        mem_addr,
    output fetch_pkg::inst_packet_t [fetch_pkg::FETCH_WIDTH-1:0] out_insts,
    output logic [fetch_pkg::FETCH_CNT_BITS-1:0]  out_num_insts
);

    // lookup, allocate and fill between the three blocks
    icache_port_if cache_bus ();

    fetch u_fetch (
        .clock         (clock),
        .rst           (rst),
        .target        (target),
        .br_task       (br_task),
        .ibuff_open    (ibuff_open),
        .fport         (cache_bus.fetch_side),
        .out_insts     (out_insts),
        .out_num_insts (out_num_insts)
    );

    miss_tracker #(
        .NUM_MEM_TAGS (NUM_MEM_TAGS)
    ) u_miss_tracker (
        .clock               (clock),
        .rst                 (rst),
        .mem_grant           (mem_grant),
        .br_task             (br_task),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .tport               (cache_bus.tracker_side)
    );

    icache #(
        .ICACHE_LINES (ICACHE_LINES)
    ) u_icache (
        .clock   (clock),
        .rst     (rst),
        .br_task (br_task),
        .cport   (cache_bus.cache_side)
    );

endmodule

//--- verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import mem_pkg::*;
    import fetch_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_MEM_TAGS = 15;
    localparam int ICACHE_LINES = 32;
    // cycle budget of each test
    localparam int RESET_LEN   = 12;
    localparam int COLD_LEN    = 60;
    localparam int PARTIAL_LEN = 100;
    localparam int CREDIT_LEN  = 30;
    localparam int SQUASH_LEN  = 100;
    localparam int TOTAL_LEN   = RESET_LEN + COLD_LEN + PARTIAL_LEN + CREDIT_LEN + SQUASH_LEN;
    // longest single wait for a fill, a request or a count
    localparam int WAIT_LIMIT  = 60;

    logic                      clock;
    logic                      rst;
    addr_t                     target;
    br_task_t                  br_task;
    logic                      mem_grant;
    logic [IBUFF_CNT_BITS-1:0] ibuff_open;
    mem_tag_t                  mem_transaction_tag;
    mem_tag_t                  mem_data_tag;
    mem_block_t                mem_data;
    logic                      mem_en;
    addr_t                     mem_addr;
    inst_packet_t [FETCH_WIDTH-1:0] out_insts;
    logic [FETCH_CNT_BITS-1:0] out_num_insts;

    // memory model state
    integer   seed;
    logic     hold_fills;
    mem_tag_t free_tags [$];
    mem_tag_t busy_tags [$];
    addr_t    busy_addr [$];
    int       busy_due [$];
    // accepted block addresses in order
    addr_t    accepted [$];
    // request as seen half a cycle before the edge
    logic     req_seen;
    addr_t    req_addr;
    mem_tag_t req_tag;

    fetch_top #(
        .NUM_MEM_TAGS (NUM_MEM_TAGS),
        .ICACHE_LINES (ICACHE_LINES)
    ) u_dut (
        .clock               (clock),
        .rst                 (rst),
        .target              (target),
        .br_task             (br_task),
        .mem_grant           (mem_grant),
        .ibuff_open          (ibuff_open),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .out_insts           (out_insts),
        .out_num_insts       (out_num_insts)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // memory word is its word address xor a fixed pattern
    function automatic logic [31:0] mem_word(input addr_t a);
        return (a >> 2) ^ 32'h5A5A_0000;
    endfunction

    function automatic mem_block_t mem_block(input addr_t b);
        mem_block_t blk;
        blk.word_level[0] = mem_word(b);
        blk.word_level[1] = mem_word(b + 32'd4);
        return blk;
    endfunction

    function automatic int count_requests(input addr_t b);
        int n;
        n = 0;
        foreach (accepted[k]) begin
            if (accepted[k] == b) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED time %0t: %s expected %0h actual %0h", $time, name, exp, act);
        stop_with_failure();
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act === exp) else report_mismatch(name, exp, act);
    endtask

    // n valid packets from target t and invalid ones after them
    task automatic check_outputs(input addr_t t, input int n);
        addr_t pc;
        compare_value("out_num_insts", n, 32'(out_num_insts));
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            pc = t + addr_t'(4 * i);
            compare_value($sformatf("out_insts[%0d].valid", i), (i < n) ? 1 : 0,
                          32'(out_insts[i].valid));
            if (i < n) begin
                compare_value($sformatf("out_insts[%0d].pc", i), pc, out_insts[i].pc);
                compare_value($sformatf("out_insts[%0d].npc", i), pc + 32'd4,
                              out_insts[i].npc);
                compare_value($sformatf("out_insts[%0d].inst", i), mem_word(pc),
                              out_insts[i].inst);
                compare_value($sformatf("out_insts[%0d].pred_taken", i), 0,
                              32'(out_insts[i].pred_taken));
            end
        end
    endtask

    task automatic apply_inputs(input addr_t t, input int open, input logic grant);
        @(posedge clock);
        target     <= t;
        ibuff_open <= IBUFF_CNT_BITS'(open);
        mem_grant  <= grant;
    endtask

    // one edge for the output register to take new inputs
    task automatic settle();
        @(posedge clock);
        @(negedge clock);
    endtask

    task automatic wait_for_count(input int n, input string what);
        int waited;
        waited = 0;
        @(negedge clock);
        while (int'(out_num_insts) != n) begin
            if (waited == WAIT_LIMIT) begin
                $display("timeout waiting for %0d instructions in %s", n, what);
                stop_with_failure();
            end else begin
                waited++;
                @(negedge clock);
            end
        end
    endtask

    task automatic wait_for_request(input addr_t b);
        int waited;
        waited = 0;
        while (count_requests(b) == 0) begin
            if (waited == WAIT_LIMIT) begin
                $display("timeout waiting for a request of block %0h", b);
                stop_with_failure();
            end else begin
                waited++;
                @(negedge clock);
            end
        end
    endtask

    task automatic wait_memory_idle();
        int waited;
        waited = 0;
        while (busy_tags.size() != 0) begin
            if (waited == WAIT_LIMIT) begin
                $display("timeout waiting for outstanding memory loads to return");
                stop_with_failure();
            end else begin
                waited++;
                @(negedge clock);
            end
        end
    endtask

    // grant held low keeps the empty cache from requesting
    task automatic reset_quiet();
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clock);
            if (c == RESET_CYCLES - 1) begin
                rst <= 1'b0;
            end
            @(negedge clock);
            compare_value("mem_en", 0, 32'(mem_en));
            check_outputs(target, 0);
        end
        // first cycle out of reset
        @(negedge clock);
        compare_value("mem_en", 0, 32'(mem_en));
        check_outputs(target, 0);
    endtask

    task automatic cold_miss();
        addr_t t;
        t = 32'h0000_1000;
        apply_inputs(t, 16, 1'b1);
        wait_for_count(4, "cold miss");
        check_outputs(t, 4);
        // refused tags must not turn into extra loads
        repeat (3) @(negedge clock);
        compare_value("requests of block 0", 1, count_requests(t));
        compare_value("requests of block 1", 1, count_requests(t + 32'd8));
    endtask

    task automatic partial_blocks();
        // odd target word
        apply_inputs(32'h0000_1004, 16, 1'b1);
        settle();
        check_outputs(32'h0000_1004, 3);
        // cache 0x1018 and 0x1020
        apply_inputs(32'h0000_1018, 16, 1'b1);
        wait_for_count(4, "second block pair");
        // 0x1028 stays missing while grant is low
        apply_inputs(32'h0000_1020, 16, 1'b0);
        settle();
        check_outputs(32'h0000_1020, 2);
        apply_inputs(32'h0000_1024, 16, 1'b0);
        settle();
        check_outputs(32'h0000_1024, 1);
        apply_inputs(32'h0000_1024, 16, 1'b1);
        wait_for_count(3, "second block fill");
        check_outputs(32'h0000_1024, 3);
    endtask

    task automatic credit_cap();
        addr_t t;
        int    avail;
        for (int odd = 0; odd < 2; odd++) begin
            t     = 32'h0000_1000 + addr_t'(4 * odd);
            avail = 4 - odd;
            // granted, but cached blocks need no load
            for (int open = 0; open <= 4; open++) begin
                apply_inputs(t, open, 1'b1);
                settle();
                check_outputs(t, (open < avail) ? open : avail);
                compare_value("mem_en", 0, 32'(mem_en));
            end
        end
        // grant low holds back the request for uncached blocks
        apply_inputs(32'h0000_1080, 16, 1'b0);
        repeat (4) begin
            @(negedge clock);
            compare_value("mem_en", 0, 32'(mem_en));
        end
        compare_value("requests of block 1080", 0, count_requests(32'h0000_1080));
    endtask

    task automatic squash_flush();
        // loads for 0x1040 and 0x1048 stay outstanding
        hold_fills = 1'b1;
        apply_inputs(32'h0000_1040, 16, 1'b1);
        wait_for_request(32'h0000_1040);
        wait_for_request(32'h0000_1048);
        apply_inputs(32'h0000_1000, 16, 1'b1);
        settle();
        check_outputs(32'h0000_1000, 4);
        @(posedge clock);
        br_task <= SQUASH;
        @(posedge clock);
        br_task <= NONE;
        @(negedge clock);
        check_outputs(32'h0000_1000, 0);
        // cached block hits again with no new load
        @(negedge clock);
        check_outputs(32'h0000_1000, 4);
        compare_value("requests of block 1000", 1, count_requests(32'h0000_1000));
        // late fills for the dropped tags
        hold_fills = 1'b0;
        wait_memory_idle();
        apply_inputs(32'h0000_1040, 16, 1'b0);
        settle();
        check_outputs(32'h0000_1040, 0);
        apply_inputs(32'h0000_1040, 16, 1'b1);
        wait_for_count(4, "refetch after squash");
        check_outputs(32'h0000_1040, 4);
        compare_value("requests of block 1040", 2, count_requests(32'h0000_1040));
        compare_value("requests of block 1048", 2, count_requests(32'h0000_1048));
    endtask

    always @(negedge clock) begin
        req_seen = mem_en && (mem_transaction_tag != '0);
        req_addr = mem_addr;
        req_tag  = mem_transaction_tag;
    end

    // tagged memory with a rotating free list, random refusals and latency
    initial begin : mem_responder
        int cycle;
        seed                = 54704;
        cycle               = 0;
        mem_transaction_tag = '0;
        mem_data_tag        = '0;
        mem_data            = '0;
        for (int t = 1; t <= NUM_MEM_TAGS; t++) begin
            free_tags.push_back(mem_tag_t'(t));
        end
        forever begin
            @(posedge clock);
            cycle++;
            mem_data_tag        <= '0;
            mem_transaction_tag <= '0;
            if (!rst) begin
                // offered tag taken at this edge
                if (req_seen) begin
                    accepted.push_back(req_addr);
                    busy_tags.push_back(req_tag);
                    busy_addr.push_back(req_addr);
                    busy_due.push_back(cycle + 3 + int'($unsigned($random(seed)) % 6));
                    void'(free_tags.pop_front());
                end
                // oldest load returns once its latency is up
                if (!hold_fills && busy_tags.size() > 0 && busy_due[0] <= cycle) begin
                    mem_data_tag <= busy_tags[0];
                    mem_data     <= mem_block(busy_addr[0]);
                    free_tags.push_back(busy_tags[0]);
                    void'(busy_tags.pop_front());
                    void'(busy_addr.pop_front());
                    void'(busy_due.pop_front());
                end
                // about one offer in four is refused with tag 0
                if (free_tags.size() > 0 && ($random(seed) & 3) != 0) begin
                    mem_transaction_tag <= free_tags[0];
                end
            end
        end
    end

    initial begin : watchdog
        repeat (2 * TOTAL_LEN) @(posedge clock);
        $display("watchdog expired after %0d cycles", 2 * TOTAL_LEN);
        stop_with_failure();
    end

    initial begin : main
        rst        = 1'b1;
        target     = '0;
        br_task    = NONE;
        mem_grant  = 1'b0;
        ibuff_open = '0;
        hold_fills = 1'b0;
        reset_quiet();
        cold_miss();
        partial_blocks();
        credit_cap();
        squash_flush();
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- sim.f
design/mem_pkg.sv
design/fetch_pkg.sv
design/icache_port_if.sv
design/icache.sv
design/miss_tracker.sv
design/fetch.sv
design/fetch_top.sv
verification/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module fetch_tb -o fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
